// ==== hw/vpat_bar_source.sv ====
`default_nettype none

`include "vpat_consts.svh"

module vpat_bar_source (
  input  logic                       vid_clk,
  input  logic                       vid_reset,
  input  logic [`VPAT_BAR_CNT_W-1:0] bar_width,
  input  vpat_pkg::vid_ctx_t         ctx,
  output vpat_pkg::bar_sample_t      bar
);

  localparam int IDX_W = $clog2(`VPAT_NUM_BARS);
  localparam logic [IDX_W-1:0] LAST_BAR = IDX_W'(`VPAT_NUM_BARS - 1);

  logic [IDX_W-1:0]           bar_idx;
  logic [`VPAT_BAR_CNT_W-1:0] pix_cnt;
  logic [IDX_W-1:0]           cur_idx;
  logic [`VPAT_BAR_CNT_W-1:0] cur_cnt;
  logic [`VPAT_BAR_CNT_W-1:0] cnt_inc;
  logic [IDX_W-1:0]           idx_nxt;
  logic [`VPAT_BAR_CNT_W-1:0] cnt_nxt;

  // position of this sample counted from line start
  assign cur_idx = ctx.line_start ? '0 : bar_idx;
  assign cur_cnt = ctx.line_start ? '0 : pix_cnt;
  assign cnt_inc = cur_cnt + 1'b1;

  // --------------------
  // run-length counting
  // --------------------
  always_comb begin
    idx_nxt = cur_idx;
    cnt_nxt = cur_cnt;
    if (ctx.pix_step) begin
      if (cnt_inc >= bar_width) begin
        cnt_nxt = '0;
        // black holds past the end of the table
        if (cur_idx != LAST_BAR) begin
          idx_nxt = cur_idx + 1'b1;
        end
      end else begin
        cnt_nxt = cnt_inc;
      end
    end
  end

  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      bar_idx <= '0;
      pix_cnt <= '0;
    end else begin
      bar_idx <= idx_nxt;
      pix_cnt <= cnt_nxt;
    end
  end

  // stage 2 register carries ctx alongside the colour
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      bar.ctx <= '0;
    end else begin
      bar.ctx <= ctx;
      // colour only needed for picture samples
      if (ctx.active) begin
        bar.color <= vpat_pkg::BAR_TABLE[cur_idx];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/vpat_consts.svh ====
`ifndef VPAT_CONSTS_SVH
`define VPAT_CONSTS_SVH

// --------------------
// video path widths
// --------------------
`define VPAT_DATA_W 20
`define VPAT_COMP_W 10

// bar generator
`define VPAT_NUM_BARS 8
`define VPAT_BAR_CNT_W 12
`define VPAT_BAR_WIDTH_RST 240

// --------------------
// wishbone register block
// --------------------
`define VPAT_WB_AW 2
`define VPAT_WB_DW 32

// register addresses
`define VPAT_REG_CTRL_ADR 2'd0
`define VPAT_REG_BAR_WIDTH_ADR 2'd1

// control register bits
`define VPAT_CTRL_ON_BIT 0
`define VPAT_CTRL_SD_BIT 1

// stages from vid_in to vid_out
`define VPAT_LATENCY 3

`endif

// ==== hw/vpat_line_tracker.sv ====
`default_nettype none

module vpat_line_tracker (
  input  logic                  vid_clk,
  input  logic                  vid_reset,
  input  vpat_pkg::pat_mode_e   mode,
  input  vpat_pkg::vid_timing_t vid_in,
  output vpat_pkg::vid_ctx_t    ctx
);

  logic [1:0] phase;
  logic       h_prev;
  logic       active;
  logic       en_active;
  logic       pix_end;

  // picture area when both V and H are clear
  assign active    = !vid_in.fvh[1] && !vid_in.fvh[0];
  assign en_active = vid_in.en && active;

  // sd pixel is cb/y or cr/y, so it ends on odd phase
  assign pix_end = (mode == vpat_pkg::PAT_MODE_SD) ? phase[0] : 1'b1;

  // --------------------
  // phase and line state
  // --------------------
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      phase  <= 2'd0;
      h_prev <= 1'b0;
    end else if (vid_in.en) begin
      h_prev <= vid_in.fvh[0];
      if (!active) begin
        phase <= 2'd0;
      end else begin
        phase <= phase + 2'd1;
      end
    end
  end

  // stage 1 register
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      ctx <= '0;
    end else begin
      ctx.sample     <= vid_in;
      ctx.phase      <= phase;
      ctx.active     <= active;
      ctx.line_start <= en_active && h_prev;
      ctx.pix_step   <= en_active && pix_end;
      ctx.blank_hold <= !active;
    end
  end

endmodule

`default_nettype wire

// ==== hw/vpat_mixer.sv ====
`default_nettype none

`include "vpat_consts.svh"

module vpat_mixer (
  input  logic                  vid_clk,
  input  logic                  vid_reset,
  input  logic                  pattern_on,
  input  vpat_pkg::pat_mode_e   mode,
  input  vpat_pkg::bar_sample_t bar,
  output vpat_pkg::vid_timing_t vid_out
);

  logic                    insert;
  logic [`VPAT_COMP_W-1:0] sd_comp;
  logic [`VPAT_DATA_W-1:0] pat_data;

  assign insert = pattern_on && bar.ctx.sample.en && !bar.ctx.blank_hold;

  // sd order on the wire is cb, y, cr, y
  always_comb begin
    case (bar.ctx.phase)
      2'd0:    sd_comp = bar.color.cb;
      2'd2:    sd_comp = bar.color.cr;
      default: sd_comp = bar.color.y;
    endcase
  end

  // --------------------
  // hd and sd packing
  // --------------------
  always_comb begin
    if (mode == vpat_pkg::PAT_MODE_SD) begin
      pat_data = {{`VPAT_COMP_W{1'b0}}, sd_comp};
    end else if (bar.ctx.phase[0]) begin
      pat_data = {bar.color.y, bar.color.cr};
    end else begin
      pat_data = {bar.color.y, bar.color.cb};
    end
  end

  // stage 3 register
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      vid_out <= '0;
    end else begin
      vid_out <= bar.ctx.sample;
      if (insert) begin
        vid_out.data <= pat_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/vpat_pkg.sv ====
`default_nettype none

`include "vpat_consts.svh"

package vpat_pkg;

  // one sample of the timing stream, fvh is {F, V, H}
  typedef struct packed {
    logic                    en;
    logic [1:0]              sync;
    logic                    trs;
    logic [2:0]              fvh;
    logic                    pic;
    logic [`VPAT_DATA_W-1:0] data;
  } vid_timing_t;

  // sample plus what the tracker worked out about it
  typedef struct packed {
    vid_timing_t sample;
    logic [1:0]  phase;
    logic        active;
    logic        line_start;
    logic        pix_step;
    logic        blank_hold;
  } vid_ctx_t;

  typedef struct packed {
    logic [`VPAT_COMP_W-1:0] cb;
    logic [`VPAT_COMP_W-1:0] cr;
    logic [`VPAT_COMP_W-1:0] y;
  } bar_color_t;

  typedef struct packed {
    vid_ctx_t   ctx;
    bar_color_t color;
  } bar_sample_t;

  typedef enum logic {
    PAT_MODE_HD = 1'b0,
    PAT_MODE_SD = 1'b1
  } pat_mode_e;

  typedef enum logic [`VPAT_WB_AW-1:0] {
    REG_CTRL      = `VPAT_REG_CTRL_ADR,
    REG_BAR_WIDTH = `VPAT_REG_BAR_WIDTH_ADR
  } vpat_reg_e;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`VPAT_WB_AW-1:0]  adr;
    logic [`VPAT_WB_DW-1:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic                    ack;
    logic [`VPAT_WB_DW-1:0]  dat;
  } wb_rsp_t;

  // 75% bars, 10-bit BT.709, left to right
  localparam bar_color_t BAR_TABLE [`VPAT_NUM_BARS] = '{
    '{cb: 10'd512, cr: 10'd512, y: 10'd721},  // white
    '{cb: 10'd176, cr: 10'd543, y: 10'd674},  // yellow
    '{cb: 10'd589, cr: 10'd176, y: 10'd581},  // cyan
    '{cb: 10'd253, cr: 10'd207, y: 10'd534},  // green
    '{cb: 10'd771, cr: 10'd817, y: 10'd251},  // magenta
    '{cb: 10'd435, cr: 10'd848, y: 10'd204},  // red
    '{cb: 10'd848, cr: 10'd481, y: 10'd111},  // blue
    '{cb: 10'd512, cr: 10'd512, y: 10'd64}    // black
  };

endpackage

`default_nettype wire

// ==== hw/vpat_top.sv ====
`default_nettype none

`include "vpat_consts.svh"

// colour-bar inserter, vid_out trails vid_in by `VPAT_LATENCY cycles
module vpat_top (
  input  logic                  vid_clk,
  input  logic                  vid_reset,
  input  vpat_pkg::wb_req_t     wb_req,
  output vpat_pkg::wb_rsp_t     wb_rsp,
  input  vpat_pkg::vid_timing_t vid_in,
  output vpat_pkg::vid_timing_t vid_out
);

  logic                       pattern_on;
  vpat_pkg::pat_mode_e        mode;
  logic [`VPAT_BAR_CNT_W-1:0] bar_width;
  vpat_pkg::vid_ctx_t         ctx;
  vpat_pkg::bar_sample_t      bar;

  // --------------------
  // host registers
  // --------------------
  vpat_wb_regs i_vpat_wb_regs (
    .vid_clk    (vid_clk),
    .vid_reset  (vid_reset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .pattern_on (pattern_on),
    .mode       (mode),
    .bar_width  (bar_width)
  );

  // --------------------
  // video pipeline
  // --------------------
  vpat_line_tracker i_vpat_line_tracker (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .mode      (mode),
    .vid_in    (vid_in),
    .ctx       (ctx)
  );

  vpat_bar_source i_vpat_bar_source (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .bar_width (bar_width),
    .ctx       (ctx),
    .bar       (bar)
  );

  vpat_mixer i_vpat_mixer (
    .vid_clk    (vid_clk),
    .vid_reset  (vid_reset),
    .pattern_on (pattern_on),
    .mode       (mode),
    .bar        (bar),
    .vid_out    (vid_out)
  );

endmodule

`default_nettype wire

// ==== hw/vpat_wb_regs.sv ====
`default_nettype none

`include "vpat_consts.svh"

module vpat_wb_regs (
  input  logic                       vid_clk,
  input  logic                       vid_reset,
  input  vpat_pkg::wb_req_t          wb_req,
  output vpat_pkg::wb_rsp_t          wb_rsp,
  output logic                       pattern_on,
  output vpat_pkg::pat_mode_e        mode,
  output logic [`VPAT_BAR_CNT_W-1:0] bar_width
);

  logic                   access;
  vpat_pkg::vpat_reg_e    reg_sel;
  logic [`VPAT_WB_DW-1:0] rd_data;

  // new cycle seen and ack not yet given
  assign access  = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
  assign reg_sel = vpat_pkg::vpat_reg_e'(wb_req.adr);

  // read mux gives zero for unmapped addresses
  always_comb begin
    rd_data = '0;
    case (reg_sel)
      vpat_pkg::REG_CTRL: begin
        rd_data[`VPAT_CTRL_ON_BIT] = pattern_on;
        rd_data[`VPAT_CTRL_SD_BIT] = mode;
      end
      vpat_pkg::REG_BAR_WIDTH: begin
        rd_data[`VPAT_BAR_CNT_W-1:0] = bar_width;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // --------------------
  // registers and ack
  // --------------------
  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      pattern_on <= 1'b0;
      mode       <= vpat_pkg::PAT_MODE_HD;
      bar_width  <= `VPAT_BAR_CNT_W'(`VPAT_BAR_WIDTH_RST);
      wb_rsp.ack <= 1'b0;
    end else begin
      wb_rsp.ack <= access;
      // read data is captured with the ack
      if (access) begin
        wb_rsp.dat <= rd_data;
      end
      // write lands together with the ack
      if (access && wb_req.we) begin
        case (reg_sel)
          vpat_pkg::REG_CTRL: begin
            pattern_on <= wb_req.dat[`VPAT_CTRL_ON_BIT];
            mode       <= vpat_pkg::pat_mode_e'(wb_req.dat[`VPAT_CTRL_SD_BIT]);
          end
          vpat_pkg::REG_BAR_WIDTH: begin
            bar_width <= wb_req.dat[`VPAT_BAR_CNT_W-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the colour-bar testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module vpat_tb -o vpat_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

# let assertion errors accumulate so the testbench can report them
sim_out=$(./obj_dir/vpat_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "=== PASS ===" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

// ==== verification/vpat_asserts.sv ====
`default_nettype none

`include "vpat_consts.svh"

module vpat_asserts (
  input logic                  vid_clk,
  input logic                  vid_reset,
  input vpat_pkg::wb_req_t     wb_req,
  input vpat_pkg::wb_rsp_t     wb_rsp,
  input vpat_pkg::vid_timing_t vid_in,
  input vpat_pkg::vid_timing_t vid_out
);
  timeunit 1ns;
  timeprecision 100ps;

  // shadow copies of the host settings
  logic                       sh_ack;
  logic                       sh_on;
  vpat_pkg::pat_mode_e        sh_mode;
  logic [`VPAT_BAR_CNT_W-1:0] sh_bw;

  // shadow line state
  logic [1:0]                 sh_phase;
  logic                       sh_h_prev;
  int unsigned                sh_samp;
  logic                       in_active;
  logic                       in_start;
  int unsigned                samp_idx;
  int unsigned                pix_idx;
  int unsigned                bw_eff;
  int unsigned                bar_num;
  logic [2:0]                 bar_sel;
  vpat_pkg::bar_color_t       color;
  logic [`VPAT_COMP_W-1:0]    sd_comp;
  vpat_pkg::vid_timing_t      exp_now;
  vpat_pkg::vid_timing_t      exp_q [`VPAT_LATENCY];

  int video_fails = 0;
  int reset_fails = 0;
  int ack_rise_fails = 0;
  int ack_once_fails = 0;
  int fail_cnt;

  assign fail_cnt = video_fails + reset_fails + ack_rise_fails + ack_once_fails;

  // --------------------
  // expected output for the sample on vid_in
  // --------------------
  always_comb begin
    in_active = !vid_in.fvh[1] && !vid_in.fvh[0];
    in_start  = vid_in.en && in_active && sh_h_prev;
    samp_idx  = in_start ? 0 : sh_samp;
    // an sd pixel is two samples wide
    pix_idx   = (sh_mode == vpat_pkg::PAT_MODE_SD) ? samp_idx / 2 : samp_idx;
    if (sh_bw == '0) begin
      bw_eff = 1;
    end else begin
      bw_eff = 32'(sh_bw);
    end
    bar_num = pix_idx / bw_eff;
    bar_sel = (bar_num > `VPAT_NUM_BARS - 1) ? 3'd7 : 3'(bar_num);
    color   = vpat_pkg::BAR_TABLE[bar_sel];
    case (sh_phase)
      2'd0:    sd_comp = color.cb;
      2'd2:    sd_comp = color.cr;
      default: sd_comp = color.y;
    endcase
    exp_now = vid_in;
    if (sh_on && vid_in.en && in_active) begin
      if (sh_mode == vpat_pkg::PAT_MODE_SD) begin
        exp_now.data = {{`VPAT_COMP_W{1'b0}}, sd_comp};
      end else begin
        exp_now.data = {color.y, sh_phase[0] ? color.cr : color.cb};
      end
    end
  end

  always_ff @(posedge vid_clk) begin
    if (vid_reset) begin
      sh_ack    <= 1'b0;
      sh_on     <= 1'b0;
      sh_mode   <= vpat_pkg::PAT_MODE_HD;
      sh_bw     <= `VPAT_BAR_CNT_W'(`VPAT_BAR_WIDTH_RST);
      sh_phase  <= 2'd0;
      sh_h_prev <= 1'b0;
      sh_samp   <= 0;
      for (int k = 0; k < `VPAT_LATENCY; k++) begin
        exp_q[k] <= '0;
      end
    end else begin
      sh_ack <= wb_req.cyc && wb_req.stb && !sh_ack;
      if (wb_req.cyc && wb_req.stb && wb_req.we && !sh_ack) begin
        if (wb_req.adr == `VPAT_REG_CTRL_ADR) begin
          sh_on   <= wb_req.dat[`VPAT_CTRL_ON_BIT];
          sh_mode <= vpat_pkg::pat_mode_e'(wb_req.dat[`VPAT_CTRL_SD_BIT]);
        end else if (wb_req.adr == `VPAT_REG_BAR_WIDTH_ADR) begin
          sh_bw <= wb_req.dat[`VPAT_BAR_CNT_W-1:0];
        end
      end
      // disabled samples leave the line state alone
      if (vid_in.en) begin
        sh_h_prev <= vid_in.fvh[0];
        sh_phase  <= in_active ? sh_phase + 2'd1 : 2'd0;
        if (in_active) begin
          sh_samp <= samp_idx + 1;
        end
      end
      exp_q[0] <= exp_now;
      for (int k = 1; k < `VPAT_LATENCY; k++) begin
        exp_q[k] <= exp_q[k-1];
      end
    end
  end

  // --------------------
  // checks
  // --------------------
  a_video: assert property (@(posedge vid_clk) disable iff (vid_reset)
    vid_out == exp_q[`VPAT_LATENCY-1])
    else begin
      video_fails++;
      $error("vid_out %h, expected %h", vid_out, exp_q[`VPAT_LATENCY-1]);
    end

  a_reset: assert property (@(posedge vid_clk)
    vid_reset |=> (!vid_out.en && vid_out.fvh == '0 && vid_out.data == '0 && !wb_rsp.ack))
    else begin
      reset_fails++;
      $error("outputs not cleared by reset");
    end

  a_ack_rise: assert property (@(posedge vid_clk) disable iff (vid_reset)
    (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
    else begin
      ack_rise_fails++;
      $error("wishbone ack missing one cycle after strobe");
    end

  a_ack_once: assert property (@(posedge vid_clk) disable iff (vid_reset)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      ack_once_fails++;
      $error("wishbone ack held longer than one cycle");
    end

endmodule

bind vpat_top vpat_asserts i_vpat_asserts (
  .vid_clk   (vid_clk),
  .vid_reset (vid_reset),
  .wb_req    (wb_req),
  .wb_rsp    (wb_rsp),
  .vid_in    (vid_in),
  .vid_out   (vid_out)
);

`default_nettype wire

// ==== verification/vpat_tb.sv ====
`default_nettype none

`include "vpat_consts.svh"

module vpat_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_TIMEOUT = 16;
  localparam int NUM_TESTS = 5;

  logic                  vid_clk;
  logic                  vid_reset;
  vpat_pkg::wb_req_t     wb_req;
  vpat_pkg::wb_rsp_t     wb_rsp;
  vpat_pkg::vid_timing_t vid_in;
  vpat_pkg::vid_timing_t vid_out;
  int                    tb_errors = 0;

  vpat_top i_vpat_top (
    .vid_clk   (vid_clk),
    .vid_reset (vid_reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .vid_in    (vid_in),
    .vid_out   (vid_out)
  );

  initial begin
    vid_clk = 1'b0;
    forever #5 vid_clk = ~vid_clk;
  end

  function automatic int total_fails();
    return tb_errors + i_vpat_top.i_vpat_asserts.fail_cnt;
  endfunction

  function automatic vpat_pkg::vid_timing_t idle_sample();
    vpat_pkg::vid_timing_t s;
    s = '0;
    s.en = 1'b1;
    s.fvh = 3'b001;
    return s;
  endfunction

  // --------------------
  // wishbone master
  // --------------------
  task automatic bus_access(input logic we, input logic [`VPAT_WB_AW-1:0] adr,
                            input logic [`VPAT_WB_DW-1:0] wdat,
                            output logic [`VPAT_WB_DW-1:0] rdat);
    vpat_pkg::wb_req_t req;
    bit acked;
    int i;
    req = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we = we;
    req.adr = adr;
    req.dat = wdat;
    acked = 1'b0;
    rdat = '0;
    @(posedge vid_clk);
    wb_req <= req;
    for (i = 0; i < ACK_TIMEOUT && !acked; i++) begin
      @(negedge vid_clk);
      if (wb_rsp.ack) begin
        acked = 1'b1;
        rdat = wb_rsp.dat;
      end
    end
    @(posedge vid_clk);
    wb_req <= '0;
    if (!acked) begin
      $display("register block never acknowledged the access to address %0d", adr);
      tb_errors++;
    end
  endtask

  task automatic reg_write(input logic [`VPAT_WB_AW-1:0] adr, input logic [31:0] dat);
    logic [`VPAT_WB_DW-1:0] unused_rd;
    bus_access(1'b1, adr, dat, unused_rd);
  endtask

  task automatic check_read(input logic [`VPAT_WB_AW-1:0] adr, input logic [31:0] exp,
                            input string name);
    logic [`VPAT_WB_DW-1:0] got;
    bus_access(1'b0, adr, '0, got);
    if (got !== exp) begin
      $display("ERR %s expected %h got %h", name, exp, got);
      tb_errors++;
    end
  endtask

  // --------------------
  // video stimulus
  // --------------------
  task automatic go_idle(input int n);
    repeat (n) begin
      @(posedge vid_clk);
      vid_in <= idle_sample();
    end
  endtask

  task automatic send_disabled(input int n);
    vpat_pkg::vid_timing_t s;
    repeat (n) begin
      s = vpat_pkg::vid_timing_t'($urandom);
      s.en = 1'b0;
      @(posedge vid_clk);
      vid_in <= s;
    end
  endtask

  // 8 samples of H blanking followed by active picture
  task automatic send_line(input int n_active, input bit gaps);
    vpat_pkg::vid_timing_t s;
    logic f;
    int sent;
    f = 1'($urandom);
    for (int i = 0; i < 8; i++) begin
      s = '0;
      s.en = 1'b1;
      s.sync = 2'($urandom);
      s.trs = (i < 4);
      s.fvh = {f, 2'b01};
      s.data = 20'($urandom);
      @(posedge vid_clk);
      vid_in <= s;
    end
    sent = 0;
    while (sent < n_active) begin
      s = '0;
      s.fvh = {f, 2'b00};
      s.pic = 1'b1;
      s.data = 20'($urandom);
      s.en = !(gaps && $urandom_range(3, 0) == 0);
      if (s.en) begin
        sent++;
      end
      @(posedge vid_clk);
      vid_in <= s;
    end
    go_idle(6);
  endtask

  task automatic report_test(input string name, input int mark);
    $display("test %s: %0d failures", name, total_fails() - mark);
  endtask

  initial begin
    logic [31:0] seed_ret;
    int mark;
    int total;
    seed_ret = $urandom(32'hdd8ecfb7);
    vid_reset = 1'b1;
    wb_req = '0;
    vid_in = idle_sample();
    repeat (2) @(posedge vid_clk);
    vid_reset <= 1'b0;
    go_idle(4);

    mark = total_fails();
    check_read(vpat_pkg::REG_CTRL, 32'd0, "REG_CTRL");
    check_read(vpat_pkg::REG_BAR_WIDTH, 32'(`VPAT_BAR_WIDTH_RST), "REG_BAR_WIDTH");
    reg_write(vpat_pkg::REG_CTRL, 32'h3);
    check_read(vpat_pkg::REG_CTRL, 32'h3, "REG_CTRL");
    reg_write(vpat_pkg::REG_BAR_WIDTH, 32'h5a5);
    check_read(vpat_pkg::REG_BAR_WIDTH, 32'h5a5, "REG_BAR_WIDTH");
    // mode bit alone tells the two control bits apart
    reg_write(vpat_pkg::REG_CTRL, 32'h2);
    check_read(vpat_pkg::REG_CTRL, 32'h2, "REG_CTRL");
    reg_write(2'd2, 32'hffff_ffff);
    check_read(2'd2, 32'd0, "unmapped 2");
    check_read(2'd3, 32'd0, "unmapped 3");
    check_read(vpat_pkg::REG_CTRL, 32'h2, "REG_CTRL");
    check_read(vpat_pkg::REG_BAR_WIDTH, 32'h5a5, "REG_BAR_WIDTH");
    reg_write(vpat_pkg::REG_CTRL, 32'h0);
    go_idle(4);
    report_test("1 register access", mark);

    mark = total_fails();
    send_disabled(12);
    send_line(20, 1'b1);
    send_disabled(5);
    send_line(20, 1'b1);
    report_test("2 pattern off", mark);

    mark = total_fails();
    reg_write(vpat_pkg::REG_BAR_WIDTH, 32'd3);
    reg_write(vpat_pkg::REG_CTRL, 32'h1);
    go_idle(4);
    send_line(30, 1'b0);
    send_line(30, 1'b0);
    report_test("3 hd bars", mark);

    mark = total_fails();
    reg_write(vpat_pkg::REG_BAR_WIDTH, 32'd2);
    reg_write(vpat_pkg::REG_CTRL, 32'h3);
    go_idle(4);
    send_line(40, 1'b0);
    send_line(40, 1'b0);
    report_test("4 sd bars", mark);

    // lines past the eighth bar with enable gaps
    mark = total_fails();
    reg_write(vpat_pkg::REG_CTRL, 32'h1);
    go_idle(4);
    send_line(40, 1'b1);
    send_line(40, 1'b1);
    reg_write(vpat_pkg::REG_BAR_WIDTH, 32'd1);
    reg_write(vpat_pkg::REG_CTRL, 32'h3);
    go_idle(4);
    send_line(40, 1'b1);
    send_line(40, 1'b1);
    go_idle(6);
    report_test("5 long lines and gaps", mark);

    total = total_fails();
    $display("tests run: %0d, failures: %0d", NUM_TESTS, total);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/vpat_pkg.sv
hw/vpat_wb_regs.sv
hw/vpat_line_tracker.sv
hw/vpat_bar_source.sv
hw/vpat_mixer.sv
hw/vpat_top.sv
verification/vpat_asserts.sv
verification/vpat_tb.sv
